//--- common/soc_ctrl_defs.svh
// Timing and address map constants shared by RTL and testbench
// Sequencing delays are in core_clk cycles
// INIT_RST_DLY must not be smaller than INIT_PWRGOOD_DLY
// Region bases only matter in bits 31:24

`ifndef SOC_CTRL_DEFS_SVH
`define SOC_CTRL_DEFS_SVH

////////////////////
// Reset sequencing
////////////////////

// Counted from the first edge with rst_n_i high
`define INIT_PWRGOOD_DLY 15
`define INIT_RST_DLY     20

// Accepted request to output change
`define HARD_RST_DLY     16
`define WARM_RST_DLY     8

////////////////////
// Address map
////////////////////

`define SOC_ADDR_W       32
`define REGION_SHIFT     24

// One byte-wide region index per base
`define SRAM_EXEC_BASE   32'h2100_0000
`define SRAM_CFG_BASE    32'h2200_0000
`define SOC_CFG_BASE     32'h2300_0000
`define DMA_BASE         32'h3000_0000

`endif

//--- common/soc_ctrl_pkg.sv
// Shared types for the reset and AXI user control block
// Struct members are listed MSB first
// Address width comes from the defs header

`default_nettype none

`include "soc_ctrl_defs.svh"

package soc_ctrl_pkg;

    // Reset request levels, held until the matching done pulse
    typedef struct packed {
        logic assert_hard;
        logic deassert_hard;
        logic assert_warm;
        logic deassert_warm;
    } rst_req_t;

    // One-cycle done pulses, same order as the requests
    typedef struct packed {
        logic assert_hard;
        logic deassert_hard;
        logic assert_warm;
        logic deassert_warm;
    } rst_done_t;

    // AXI user straps
    typedef struct packed {
        logic [31:0] mcu_lsu;
        logic [31:0] mcu_ifu;
        logic [31:0] mcu_sram_cfg;
        logic [31:0] mci_soc_cfg;
        logic [31:0] cptra_dma;
    } strap_t;

    // Set bit selects the raw strap over the default copy
    typedef struct packed {
        logic sram_cfg_ovr;
        logic soc_cfg_ovr;
    } strap_ovr_t;

    typedef enum logic [2:0] {
        REG_NONE      = 3'd0,
        REG_SRAM_EXEC = 3'd1,
        REG_SRAM_CFG  = 3'd2,
        REG_SOC_CFG   = 3'd3,
        REG_DMA       = 3'd4
    } region_e;

    // Single access request word
    typedef struct packed {
        logic                   valid;
        logic [31:0]            user;
        logic [`SOC_ADDR_W-1:0] addr;
        logic                   write;
    } acc_req_t;

    // Filter verdict, user echoed back
    typedef struct packed {
        logic        valid;
        logic        grant;
        region_e     region;
        logic [31:0] user;
    } acc_rsp_t;

endpackage

`default_nettype wire

//--- reset_seq/reset_seq.sv
// Hard and warm reset sequencer
// Requests are levels and must drop the cycle after their done pulse
// A busy channel ignores new requests, so the SoC just sees a late done
// Warm output is forced low whenever power-good is low

`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_defs.svh"

module reset_seq
    import soc_ctrl_pkg::*;
(
    input  wire logic core_clk,
    input  wire logic rst_n_i,
    input  rst_req_t  rst_req_i,
    output logic      pwrgood_o,
    output logic      cptra_rst_b_o,
    output rst_done_t rst_done_o
);

    // Init counter sized for the later of the two init steps
    localparam int INIT_CNT_W = $clog2(`INIT_RST_DLY + 1);
    localparam logic [INIT_CNT_W-1:0] PG_AT  = INIT_CNT_W'(`INIT_PWRGOOD_DLY);
    localparam logic [INIT_CNT_W-1:0] RST_AT = INIT_CNT_W'(`INIT_RST_DLY);

    // Channel counters hold DLY-1 at most
    localparam int MAX_DLY = (`HARD_RST_DLY > `WARM_RST_DLY) ? `HARD_RST_DLY : `WARM_RST_DLY;
    localparam int CNT_W   = (MAX_DLY > 2) ? $clog2(MAX_DLY) : 1;

    logic [INIT_CNT_W-1:0] init_cnt_q;
    logic                  init_done_q;
    logic                  pg_fire;
    logic                  rst_fire;

    // Per-channel inputs, index 0 hard and index 1 warm
    logic [1:0] ch_asrt;
    logic [1:0] ch_deasrt;
    logic [1:0] ch_allow;
    logic [1:0] ch_init;

    ////////////////////
    // Power-up init
    ////////////////////

    // Counts edges after reset release, stops once the core reset is out
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            init_cnt_q  <= '0;
            init_done_q <= 1'b0;
        end else if (!init_done_q) begin
            init_cnt_q <= init_cnt_q + 1'b1;
            if (rst_fire) begin
                init_done_q <= 1'b1;
            end
        end
    end

    // Pre-increment value equals the delay on the edge that must fire
    assign pg_fire  = !init_done_q && (init_cnt_q == PG_AT);
    assign rst_fire = !init_done_q && (init_cnt_q == RST_AT);

    ////////////////////
    // Request channels
    ////////////////////

    assign ch_asrt   = {rst_req_i.assert_warm, rst_req_i.assert_hard};
    assign ch_deasrt = {rst_req_i.deassert_warm, rst_req_i.deassert_hard};
    // Warm deassert waits for power-good
    assign ch_allow  = {pwrgood_o, 1'b1};
    assign ch_init   = {rst_fire, pg_fire};

    for (genvar ch = 0; ch < 2; ch++) begin : g_ch
        localparam int DLY = (ch == 0) ? `HARD_RST_DLY : `WARM_RST_DLY;
        localparam logic [CNT_W-1:0] LOAD = CNT_W'(DLY - 1);

        logic [CNT_W-1:0] cnt_q;
        logic             busy_q;
        // 1 means the pending change releases the reset
        logic             pend_q;
        logic             out_q;
        logic             done_asrt_q;
        logic             done_deasrt_q;
        logic             accept;

        // Deassert wins, and blocks assert while it is held back
        assign accept = init_done_q && !busy_q &&
                        (ch_deasrt[ch] ? ch_allow[ch] : ch_asrt[ch]);

        always_ff @(posedge core_clk) begin
            if (!rst_n_i) begin
                cnt_q         <= '0;
                busy_q        <= 1'b0;
                pend_q        <= 1'b0;
                out_q         <= 1'b0;
                done_asrt_q   <= 1'b0;
                done_deasrt_q <= 1'b0;
            end else begin
                // Done bits are single-cycle
                done_asrt_q   <= 1'b0;
                done_deasrt_q <= 1'b0;
                if (ch_init[ch]) begin
                    out_q <= 1'b1;
                end
                if (accept) begin
                    busy_q <= 1'b1;
                    cnt_q  <= LOAD;
                    pend_q <= ch_deasrt[ch];
                end else if (busy_q) begin
                    if (cnt_q == '0) begin
                        // Output change and done share this edge
                        busy_q        <= 1'b0;
                        out_q         <= pend_q;
                        done_deasrt_q <= pend_q;
                        done_asrt_q   <= !pend_q;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign pwrgood_o     = g_ch[0].out_q;
    // Core reset held whenever power-good is low
    assign cptra_rst_b_o = g_ch[1].out_q & g_ch[0].out_q;

    assign rst_done_o.assert_hard   = g_ch[0].done_asrt_q;
    assign rst_done_o.deassert_hard = g_ch[0].done_deasrt_q;
    assign rst_done_o.assert_warm   = g_ch[1].done_asrt_q;
    assign rst_done_o.deassert_warm = g_ch[1].done_deasrt_q;

endmodule

`default_nettype wire

//--- strap/strap_latch.sv
// AXI user strap capture on the power-good rising edge
// Straps are static pins, sampled one cycle after power-good rises
// Output is zero until the first rise

`timescale 1ns/1ps
`default_nettype none

module strap_latch
    import soc_ctrl_pkg::*;
(
    input  wire logic core_clk,
    input  wire logic rst_n_i,
    input  wire logic pwrgood_i,
    input  strap_t    strap_i,
    input  strap_ovr_t strap_ovr_i,
    output strap_t    straps_o
);

    logic   pwrgood_q;
    logic   pwrgood_rise;
    strap_t strap_next;
    strap_t straps_q;

    ////////////////////
    // Edge detect
    ////////////////////

    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            pwrgood_q <= 1'b0;
        end else begin
            pwrgood_q <= pwrgood_i;
        end
    end

    assign pwrgood_rise = pwrgood_i && !pwrgood_q;

    ////////////////////
    // Default rules
    ////////////////////

    always_comb begin
        // Straps without a default pass through as given
        strap_next.mcu_lsu   = strap_i.mcu_lsu;
        strap_next.mcu_ifu   = strap_i.mcu_ifu;
        strap_next.cptra_dma = strap_i.cptra_dma;

        // SRAM config user follows the DMA user unless overridden
        strap_next.mcu_sram_cfg = strap_ovr_i.sram_cfg_ovr ? strap_i.mcu_sram_cfg
                                                           : strap_i.cptra_dma;

        // SoC config user follows the LSU user unless overridden
        strap_next.mci_soc_cfg = strap_ovr_i.soc_cfg_ovr ? strap_i.mci_soc_cfg
                                                         : strap_i.mcu_lsu;
    end

    ////////////////////
    // Capture
    ////////////////////

    // Holds until the next power-good rise
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            straps_q <= '0;
        end else if (pwrgood_rise) begin
            straps_q <= strap_next;
        end
    end

    assign straps_o = straps_q;

endmodule

`default_nettype wire

//--- rtl/axi_user_filter.sv
// AXI user check by address region
// One request word per cycle, one registered response per request
// All grants are dropped while the core reset is held

`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_defs.svh"

module axi_user_filter
    import soc_ctrl_pkg::*;
(
    input  wire logic core_clk,
    input  wire logic rst_n_i,
    input  wire logic cptra_rst_b_i,
    input  strap_t    straps_i,
    input  acc_req_t  acc_req_i,
    output acc_rsp_t  acc_rsp_o
);

    localparam int RIDX_W = `SOC_ADDR_W - `REGION_SHIFT;

    // Full bases, only the top byte is compared
    localparam logic [`SOC_ADDR_W-1:0] SRAM_EXEC_BASE = `SRAM_EXEC_BASE;
    localparam logic [`SOC_ADDR_W-1:0] SRAM_CFG_BASE  = `SRAM_CFG_BASE;
    localparam logic [`SOC_ADDR_W-1:0] SOC_CFG_BASE   = `SOC_CFG_BASE;
    localparam logic [`SOC_ADDR_W-1:0] DMA_BASE       = `DMA_BASE;

    logic [RIDX_W-1:0] ridx;
    region_e           region;
    logic              user_ok;

    logic              rsp_valid_q;
    logic              rsp_grant_q;
    region_e           rsp_region_q;
    logic [31:0]       rsp_user_q;

    ////////////////////
    // Region decode
    ////////////////////

    assign ridx = acc_req_i.addr[`SOC_ADDR_W-1:`REGION_SHIFT];

    always_comb begin
        if (ridx == SRAM_EXEC_BASE[`SOC_ADDR_W-1:`REGION_SHIFT]) begin
            region = REG_SRAM_EXEC;
        end else if (ridx == SRAM_CFG_BASE[`SOC_ADDR_W-1:`REGION_SHIFT]) begin
            region = REG_SRAM_CFG;
        end else if (ridx == SOC_CFG_BASE[`SOC_ADDR_W-1:`REGION_SHIFT]) begin
            region = REG_SOC_CFG;
        end else if (ridx == DMA_BASE[`SOC_ADDR_W-1:`REGION_SHIFT]) begin
            region = REG_DMA;
        end else begin
            region = REG_NONE;
        end
    end

    ////////////////////
    // User check
    ////////////////////

    always_comb begin
        case (region)
            // MCU fetch and load/store both reach the exec SRAM
            REG_SRAM_EXEC: user_ok = (acc_req_i.user == straps_i.mcu_ifu) ||
                                     (acc_req_i.user == straps_i.mcu_lsu);
            REG_SRAM_CFG:  user_ok = (acc_req_i.user == straps_i.mcu_sram_cfg);
            REG_SOC_CFG:   user_ok = (acc_req_i.user == straps_i.mci_soc_cfg);
            REG_DMA:       user_ok = (acc_req_i.user == straps_i.cptra_dma);
            default:       user_ok = 1'b0;
        endcase
    end

    ////////////////////
    // Response register
    ////////////////////

    // Response valid tracks request valid
    always_ff @(posedge core_clk) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= acc_req_i.valid;
        end
    end

    always_ff @(posedge core_clk) begin
        // Region and user still reported under reset
        rsp_grant_q  <= user_ok && cptra_rst_b_i;
        rsp_region_q <= region;
        rsp_user_q   <= acc_req_i.user;
    end

    assign acc_rsp_o.valid  = rsp_valid_q;
    assign acc_rsp_o.grant  = rsp_grant_q;
    assign acc_rsp_o.region = rsp_region_q;
    assign acc_rsp_o.user   = rsp_user_q;

endmodule

`default_nettype wire

//--- rtl/soc_ctrl_top.sv
// Reset and AXI user control block top level
// No registering here, latencies are those of the submodules
// Straps and overrides are expected static around power-good rise

`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top
    import soc_ctrl_pkg::*;
(
    input  wire logic  core_clk,
    input  wire logic  rst_n_i,
    input  rst_req_t   rst_req_i,
    input  strap_t     strap_i,
    input  strap_ovr_t strap_ovr_i,
    input  acc_req_t   acc_req_i,
    output logic       pwrgood_o,
    output logic       cptra_rst_b_o,
    output rst_done_t  rst_done_o,
    output strap_t     straps_o,
    output acc_rsp_t   acc_rsp_o
);

    ////////////////////
    // Reset sequencing
    ////////////////////

    // Drives power-good and the gated core reset
    reset_seq reset_seq_inst (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .rst_req_i     (rst_req_i),
        .pwrgood_o     (pwrgood_o),
        .cptra_rst_b_o (cptra_rst_b_o),
        .rst_done_o    (rst_done_o)
    );

    ////////////////////
    // Strap capture
    ////////////////////

    // Latched straps go out and into the filter
    strap_latch strap_latch_inst (
        .core_clk    (core_clk),
        .rst_n_i     (rst_n_i),
        .pwrgood_i   (pwrgood_o),
        .strap_i     (strap_i),
        .strap_ovr_i (strap_ovr_i),
        .straps_o    (straps_o)
    );

    ////////////////////
    // Access filter
    ////////////////////

    // Denies everything while the core is in reset
    axi_user_filter axi_user_filter_inst (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .cptra_rst_b_i (cptra_rst_b_o),
        .straps_i      (straps_o),
        .acc_req_i     (acc_req_i),
        .acc_rsp_o     (acc_rsp_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// Testbench clock and reset source
// 20 ns core_clk, reset held low for the first 10 cycles
// Reset is released on a falling edge

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 10
) (
    output logic core_clk_o,
    output logic rst_n_o
);

    initial begin
        core_clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) core_clk_o = ~core_clk_o;
        end
    end

    // Release after RST_CYCLES rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(negedge core_clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/soc_ctrl_tb.sv
// Testbench for the reset and AXI user control block
// Commands come from verif/soc_ctrl_stimulus.txt, run from the project root
// INIT must follow at most one STRAP line so it sees the reset release
// Inputs change on falling edges, outputs are sampled there too

`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_defs.svh"

module soc_ctrl_tb
    import soc_ctrl_pkg::*;
;

    localparam logic [7:0] K_STRAP = 8'd1;
    localparam logic [7:0] K_INIT  = 8'd2;
    localparam logic [7:0] K_RST   = 8'd3;
    localparam logic [7:0] K_ACC   = 8'd4;
    localparam int SUM_DLY = `INIT_PWRGOOD_DLY + `INIT_RST_DLY + `HARD_RST_DLY + `WARM_RST_DLY;

    typedef struct packed {
        logic [7:0]       kind;
        logic [6:0][31:0] arg;
    } cmd_t;

    logic       core_clk;
    logic       rst_n;
    rst_req_t   rst_req;
    strap_t     strap_drv;
    strap_ovr_t ovr_drv;
    acc_req_t   acc_req;
    logic       pwrgood;
    logic       cptra_rst_b;
    rst_done_t  rst_done;
    strap_t     straps;
    acc_rsp_t   acc_rsp;

    cmd_t   cmds[$];
    strap_t exp_straps;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    int     cycle_limit;
    int     seed;

    // Outstanding access, checked on the next falling edge
    logic        pend_valid;
    logic        pend_grant;
    region_e     pend_region;
    logic [31:0] pend_user;
    int          pend_test;
    int          pend_err;

    tb_clk_gen clk_gen_inst (
        .core_clk_o (core_clk),
        .rst_n_o    (rst_n)
    );

    soc_ctrl_top soc_ctrl_top_inst (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n),
        .rst_req_i     (rst_req),
        .strap_i       (strap_drv),
        .strap_ovr_i   (ovr_drv),
        .acc_req_i     (acc_req),
        .pwrgood_o     (pwrgood),
        .cptra_rst_b_o (cptra_rst_b),
        .rst_done_o    (rst_done),
        .straps_o      (straps),
        .acc_rsp_o     (acc_rsp)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic finish_test(input string name, input int id, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("Test %0d (%s): failed", id, name);
        end else begin
            $display("Test %0d (%s): ok", id, name);
        end
    endtask

    // Latched strap values as the default rules give them
    function automatic strap_t apply_defaults(input strap_t s, input strap_ovr_t o);
        strap_t r;
        r = s;
        if (!o.sram_cfg_ovr) begin
            r.mcu_sram_cfg = s.cptra_dma;
        end
        if (!o.soc_cfg_ovr) begin
            r.mci_soc_cfg = s.mcu_lsu;
        end
        return r;
    endfunction

    // Falling edges from request until its done pulse is seen
    function automatic int done_edge(input int bit_i, input logic [3:0] mask,
                                     input logic pg_start);
        int r;
        case (bit_i)
            3, 2: r = `HARD_RST_DLY + 1;
            1: r = `WARM_RST_DLY + 1;
            default: begin
                if (pg_start) begin
                    r = `WARM_RST_DLY + 1;
                end else if (mask[2]) begin
                    // Waits one edge for power-good to be seen high
                    r = `HARD_RST_DLY + `WARM_RST_DLY + 2;
                end else begin
                    r = 0;
                end
            end
        endcase
        return r;
    endfunction

    // Output moved by a request bit, hard bits drive power-good
    function automatic logic req_output(input int bit_i);
        return (bit_i >= 2) ? pwrgood : cptra_rst_b;
    endfunction

    // Deassert bits release their output, assert bits pull it low
    function automatic logic done_level(input int bit_i);
        return (bit_i == 2 || bit_i == 0);
    endfunction

    task automatic check_straps();
        if (straps !== exp_straps) begin
            errors++;
            $display("[FAIL] %0t: straps_o is %h, expected %h", $time, straps, exp_straps);
        end
    endtask

    ////////////////////
    // Access stream
    ////////////////////

    task automatic check_rsp();
        if (acc_rsp.valid !== 1'b1) report_mismatch("rsp valid", 32'(acc_rsp.valid), 32'd1);
        if (acc_rsp.grant !== pend_grant) begin
            report_mismatch("rsp grant", 32'(acc_rsp.grant), 32'(pend_grant));
        end
        if (acc_rsp.region !== pend_region) begin
            report_mismatch("rsp region", 32'(acc_rsp.region), 32'(pend_region));
        end
        if (acc_rsp.user !== pend_user) report_mismatch("rsp user", acc_rsp.user, pend_user);
        finish_test("ACC", pend_test, pend_err);
        pend_valid = 1'b0;
    endtask

    // One request per falling edge, previous response checked first
    task automatic acc_step(input int id, input acc_req_t req, input logic exp_grant,
                            input region_e exp_region);
        @(negedge core_clk);
        if (pend_valid) begin
            check_rsp();
        end
        acc_req     = req;
        pend_valid  = 1'b1;
        pend_grant  = exp_grant;
        pend_region = exp_region;
        pend_user   = req.user;
        pend_test   = id;
        pend_err    = errors;
    endtask

    task automatic acc_flush();
        if (pend_valid) begin
            @(negedge core_clk);
            check_rsp();
            acc_req = '0;
            @(negedge core_clk);
            if (acc_rsp.valid !== 1'b0) begin
                report_mismatch("rsp valid after stream", 32'(acc_rsp.valid), 32'd0);
            end
        end
    endtask

    ////////////////////
    // Reset commands
    ////////////////////

    task automatic run_init();
        logic released;
        int   k;
        released = 1'b0;
        while (!released) begin
            @(negedge core_clk);
            if (rst_n) begin
                released = 1'b1;
            end else begin
                if (pwrgood !== 1'b0) report_mismatch("pwrgood in reset", 32'(pwrgood), 0);
                if (cptra_rst_b !== 1'b0) begin
                    report_mismatch("cptra_rst_b in reset", 32'(cptra_rst_b), 0);
                end
                if (rst_done !== '0) report_mismatch("done in reset", 32'(rst_done), 0);
            end
        end
        // k counts edges after the first one with reset high
        for (k = 0; k <= `INIT_RST_DLY + 2; k++) begin
            if (k > 0) begin
                @(negedge core_clk);
            end
            if (pwrgood !== (k >= `INIT_PWRGOOD_DLY)) begin
                report_mismatch($sformatf("pwrgood at init edge %0d", k), 32'(pwrgood),
                                32'(k >= `INIT_PWRGOOD_DLY));
            end
            if (cptra_rst_b !== (k >= `INIT_RST_DLY)) begin
                report_mismatch($sformatf("cptra_rst_b at init edge %0d", k),
                                32'(cptra_rst_b), 32'(k >= `INIT_RST_DLY));
            end
            if (k == `INIT_PWRGOOD_DLY) begin
                exp_straps = apply_defaults(strap_drv, ovr_drv);
            end
        end
        check_straps();
    endtask

    task automatic run_rst(input logic [3:0] mask, input logic exp_pg, input logic exp_rstb);
        logic [3:0] req;
        logic [3:0] seen;
        logic [3:0] start_lvl;
        logic       pg_start;
        int         exp_at[4];
        int         k;
        @(negedge core_clk);
        pg_start  = pwrgood;
        // Level each output keeps until its own done pulse
        start_lvl = {pwrgood, pwrgood, cptra_rst_b, cptra_rst_b};
        for (int i = 0; i < 4; i++) begin
            exp_at[i] = done_edge(i, mask, pg_start);
        end
        req     = mask;
        seen    = '0;
        rst_req = rst_req_t'(req);
        k       = 0;
        while (seen != mask && k < 64) begin
            @(negedge core_clk);
            k++;
            for (int i = 0; i < 4; i++) begin
                if (rst_done[i]) begin
                    if (!mask[i] || seen[i]) begin
                        errors++;
                        $display("Unexpected done pulse on bit %0d at %0t", i, $time);
                    end else begin
                        if (k != exp_at[i]) begin
                            report_mismatch($sformatf("done %0d edge", i), k, exp_at[i]);
                        end
                        // Output change shares the cycle of its done pulse
                        if (req_output(i) !== done_level(i)) begin
                            report_mismatch($sformatf("output at done %0d", i),
                                            32'(req_output(i)), 32'(done_level(i)));
                        end
                        seen[i] = 1'b1;
                        // SoC drops the request right after its done
                        req[i]  = 1'b0;
                        if (i == 2) begin
                            exp_straps = apply_defaults(strap_drv, ovr_drv);
                        end
                    end
                end else if (mask[i] && !seen[i] && req_output(i) !== start_lvl[i]) begin
                    report_mismatch($sformatf("output before done %0d", i),
                                    32'(req_output(i)), 32'(start_lvl[i]));
                end
            end
            // Core reset forced whenever power-good is low
            if (!pwrgood && cptra_rst_b !== 1'b0) begin
                report_mismatch("cptra_rst_b with pwrgood low", 32'(cptra_rst_b), 0);
            end
            rst_req = rst_req_t'(req);
        end
        if (seen != mask) begin
            errors++;
            $display("Reset request %0h never completed, done bits seen %0h", mask, seen);
            rst_req = '0;
        end
        @(negedge core_clk);
        if (rst_done !== '0) report_mismatch("done after pulse", 32'(rst_done), 0);
        if (pwrgood !== exp_pg) report_mismatch("pwrgood", 32'(pwrgood), 32'(exp_pg));
        if (cptra_rst_b !== exp_rstb) begin
            report_mismatch("cptra_rst_b", 32'(cptra_rst_b), 32'(exp_rstb));
        end
        check_straps();
    endtask

    task automatic run_strap(input cmd_t c);
        @(negedge core_clk);
        check_straps();
        strap_drv = {c.arg[0], c.arg[1], c.arg[2], c.arg[3], c.arg[4]};
        ovr_drv   = {c.arg[5][0], c.arg[6][0]};
        // New pins must not show before a power-good rise
        @(negedge core_clk);
        check_straps();
    endtask

    ////////////////////
    // Stimulus file
    ////////////////////

    function automatic logic read_stimulus();
        int    fd;
        int    r;
        string word;
        string line;
        cmd_t  c;
        fd = $fopen("verif/soc_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            c = '0;
            r = $fscanf(fd, "%s", word);
            if (r == 1) begin
                if (word.substr(0, 0) == "#") begin
                    r = $fgets(line, fd);
                end else if (word == "STRAP") begin
                    c.kind = K_STRAP;
                    r = $fscanf(fd, "%h %h %h %h %h %h %h", c.arg[0], c.arg[1], c.arg[2],
                                c.arg[3], c.arg[4], c.arg[5], c.arg[6]);
                    cmds.push_back(c);
                end else if (word == "INIT") begin
                    c.kind = K_INIT;
                    cmds.push_back(c);
                end else if (word == "RST") begin
                    c.kind = K_RST;
                    r = $fscanf(fd, "%h %h %h", c.arg[0], c.arg[1], c.arg[2]);
                    cmds.push_back(c);
                end else if (word == "ACC") begin
                    c.kind = K_ACC;
                    r = $fscanf(fd, "%h %h %h %h %h %h", c.arg[0], c.arg[1], c.arg[2],
                                c.arg[3], c.arg[4], c.arg[5]);
                    cmds.push_back(c);
                end
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst_req      = '0;
        strap_drv    = '0;
        ovr_drv      = '0;
        acc_req      = '0;
        exp_straps   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 43;
        pend_valid   = 1'b0;
        pend_grant   = 1'b0;
        pend_region  = REG_NONE;
        pend_user    = '0;
        pend_test    = 0;
        pend_err     = 0;
        cycle_limit  = 20 * SUM_DLY;
        if (!read_stimulus()) begin
            $display("Could not open the stimulus file verif/soc_ctrl_stimulus.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            cycle_limit = cycle_limit + cmds.size();
            foreach (cmds[i]) begin
                int          e0;
                acc_req_t    req;
                logic        g;
                e0 = errors;
                if (cmds[i].kind == K_ACC) begin
                    req.valid = 1'b1;
                    req.user  = cmds[i].arg[1];
                    req.addr  = cmds[i].arg[2];
                    req.write = cmds[i].arg[3][0];
                    g         = cmds[i].arg[4][0];
                    if (cmds[i].arg[0][0]) begin
                        // Filler user that owns nothing, so always denied
                        do begin
                            req.user = $random(seed);
                        end while (req.user == exp_straps.mcu_lsu ||
                                   req.user == exp_straps.mcu_ifu ||
                                   req.user == exp_straps.mcu_sram_cfg ||
                                   req.user == exp_straps.mci_soc_cfg ||
                                   req.user == exp_straps.cptra_dma);
                        g = 1'b0;
                    end
                    acc_step(i, req, g, region_e'(cmds[i].arg[5][2:0]));
                end else begin
                    acc_flush();
                    if (cmds[i].kind == K_STRAP) begin
                        run_strap(cmds[i]);
                        finish_test("STRAP", i, e0);
                    end else if (cmds[i].kind == K_INIT) begin
                        run_init();
                        finish_test("INIT", i, e0);
                    end else begin
                        run_rst(cmds[i].arg[0][3:0], cmds[i].arg[1][0], cmds[i].arg[2][0]);
                        finish_test("RST", i, e0);
                    end
                end
            end
            acc_flush();
            $display("Tests run %0d, failed %0d, mismatches %0d",
                     tests_run, tests_failed, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // Run limit
    always @(posedge core_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        cycles = 0;
    end

endmodule

`default_nettype wire

//--- verif/soc_ctrl_stimulus.txt
# STRAP mcu_lsu mcu_ifu mcu_sram_cfg mci_soc_cfg cptra_dma sram_cfg_ovr soc_cfg_ovr
# RST mask(8 ah,4 dh,2 aw,1 dw) pwrgood cptra_rst_b | ACC rnd user addr write grant region
STRAP 00000010 00000011 00000012 00000013 00000014 0 0
INIT
ACC 0 00000010 21000100 0 1 1
ACC 0 00000011 21000200 1 1 1
ACC 0 00000014 22000000 0 1 2
ACC 0 00000012 22000004 1 0 2
ACC 0 00000010 23000010 0 1 3
ACC 0 00000013 23000010 0 0 3
ACC 0 00000014 30001000 1 1 4
ACC 0 00000011 30001000 0 0 4
ACC 0 00000010 40000000 0 0 0
ACC 1 00000000 21000000 0 0 1
ACC 1 00000000 30000000 0 0 4
STRAP 00000020 00000021 00000022 00000023 00000024 1 1
RST 8 0 0
RST 4 1 1
ACC 0 00000022 22000000 0 1 2
ACC 0 00000024 22000000 0 0 2
ACC 0 00000023 23000000 1 1 3
ACC 0 00000020 23000000 0 0 3
RST 2 1 0
ACC 0 00000021 21000000 0 0 1
ACC 0 00000024 30000000 1 0 4
ACC 0 00000023 23000000 0 0 3
RST 1 1 1
RST 8 0 0
RST 2 0 0
RST 5 1 1
ACC 0 00000020 21000000 0 1 1
ACC 1 00000000 22000000 0 0 2

//--- soc_ctrl_top.f
+incdir+common
common/soc_ctrl_pkg.sv
reset_seq/reset_seq.sv
strap/strap_latch.sv
rtl/axi_user_filter.sv
rtl/soc_ctrl_top.sv
verif/tb_clk_gen.sv
verif/soc_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module soc_ctrl_tb -f soc_ctrl_top.f -o Vsoc_ctrl_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vsoc_ctrl_tb)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^ALL CHECKS PASSED$"; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi
